/* common/mem_pkg.sv */
package mem_pkg;

    // RAM geometry, in 32-bit words.
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = 10;

    // Load/store width, encoded as in funct3.
    typedef enum logic [2:0] {
        SIZE_B  = 3'b000,
        SIZE_H  = 3'b001,
        SIZE_W  = 3'b010,
        SIZE_BU = 3'b100,
        SIZE_HU = 3'b101
    } access_size_e;

    // Request from the load/store unit.
    // Held stable by the core while miss is high.
    typedef struct packed {
        logic [31:0]  addr;
        logic [31:0]  wdata;
        access_size_e size;
        logic         wr;
        logic         rd;
    } cpu_req_t;

    // One-cycle pulses from the cache to the counters.
    typedef struct packed {
        logic done;       // Access completed this cycle.
        logic miss_start; // Miss sequence began.
        logic misaligned; // Completed access was misaligned.
    } cache_evt_t;

endpackage

/* common/csr_pkg.sv */
package csr_pkg;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Register byte offsets.
    localparam logic [3:0] REG_CTRL       = 4'h0;
    localparam logic [3:0] REG_ACCESSES   = 4'h4;
    localparam logic [3:0] REG_MISSES     = 4'h8;
    localparam logic [3:0] REG_MISALIGNED = 4'hC;

    // Control register bits.
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_FLUSH_BIT  = 1;

    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

/* dcache/riscv_dcache.sv */
module riscv_dcache (
    input  logic                       clk_in,
    input  logic                       rst_in,
    input  mem_pkg::cpu_req_t          req,
    output logic [31:0]                rdata,
    output logic                       miss,
    input  logic                       enable,
    input  logic                       flush,
    output mem_pkg::cache_evt_t        evt,
    output logic [mem_pkg::RAM_AW-1:0] mem_addr,
    output logic [31:0]                mem_wdata,
    output logic [3:0]                 mem_be,
    input  logic [31:0]                mem_rdata
);
    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        WAIT2
    } state_e;

    state_e      state;
    logic        valid;
    logic [31:0] rec_addr;
    logic        active;
    logic        hit;
    logic        misaligned;
    logic [31:0] lane_data;

    assign active = req.rd | req.wr;
    assign hit    = valid && enable && (rec_addr == req.addr);
    assign miss   = active && !hit && (state != WAIT2); // RAM output is valid in WAIT2.

    assign mem_addr  = req.addr[mem_pkg::RAM_AW+1:2];
    assign lane_data = mem_rdata >> {req.addr[1:0], 3'b000}; // Selected bytes to bit 0.

    assign evt.done       = active && !miss;
    assign evt.miss_start = active && !hit && (state == IDLE);
    assign evt.misaligned = active && !miss && misaligned;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= IDLE;
            valid <= 1'b0;
        end else begin
            case (state)
                IDLE: if (active && !hit) state <= WAIT;
                WAIT: state <= WAIT2;
                default: begin
                    state <= IDLE;
                    valid <= 1'b1;
                end
            endcase
            if (flush || !enable) valid <= 1'b0; // Overrides the record set in WAIT2.
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == WAIT2) rec_addr <= req.addr;
    end

    always_comb begin
        case (req.size)
            mem_pkg::SIZE_H, mem_pkg::SIZE_HU: misaligned = req.addr[0];
            mem_pkg::SIZE_W:                   misaligned = (req.addr[1:0] != 2'b00);
            default:                           misaligned = 1'b0;
        endcase
    end

    // Store lanes. Data is replicated and the byte enables pick the lanes.
    always_comb begin
        mem_wdata = 32'h0;
        mem_be    = 4'b0000;
        if (req.wr && !misaligned) begin
            case (req.size)
                mem_pkg::SIZE_B: begin
                    mem_wdata = {4{req.wdata[7:0]}};
                    mem_be    = 4'b0001 << req.addr[1:0];
                end
                mem_pkg::SIZE_H: begin
                    mem_wdata = {2{req.wdata[15:0]}};
                    mem_be    = req.addr[1] ? 4'b1100 : 4'b0011;
                end
                mem_pkg::SIZE_W: begin
                    mem_wdata = req.wdata;
                    mem_be    = 4'b1111;
                end
                default: mem_be = 4'b0000; // No unsigned stores.
            endcase
        end
    end

    // Load extraction and extension.
    always_comb begin
        rdata = 32'h0;
        if (req.rd && !misaligned) begin
            case (req.size)
                mem_pkg::SIZE_B:  rdata = {{24{lane_data[7]}}, lane_data[7:0]};
                mem_pkg::SIZE_BU: rdata = {24'h0, lane_data[7:0]};
                mem_pkg::SIZE_H:  rdata = {{16{lane_data[15]}}, lane_data[15:0]};
                mem_pkg::SIZE_HU: rdata = {16'h0, lane_data[15:0]};
                mem_pkg::SIZE_W:  rdata = mem_rdata;
                default:          rdata = 32'h0;
            endcase
        end
    end

    // Wider than a byte at an odd address, or a word off its boundary.
    a_misaligned_no_write: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (req.wr && req.size != mem_pkg::SIZE_B &&
         (req.addr[0] || (req.addr[1] && req.size == mem_pkg::SIZE_W)))
        |-> (mem_be == 4'b0000)
    );

    // Miss ends after two cycles unless the core moves to another request.
    a_miss_two_cycles: assert property (
        @(posedge clk_in) disable iff (rst_in)
        miss ##1 (miss && $stable(req)) |=> (!miss || !$stable(req))
    );

endmodule

/* verilog/data_ram.sv */
module data_ram (
    input  logic                       clk_in,
    input  logic [mem_pkg::RAM_AW-1:0] addr,
    input  logic [31:0]                wdata,
    input  logic [3:0]                 be,
    output logic [31:0]                rdata
);
    logic [31:0] mem [mem_pkg::RAM_WORDS];
    logic [31:0] rd_stage1;
    logic [31:0] rd_stage2;

    // Byte-wise write.
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < 4; i++) begin
            if (be[i]) mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
        end
    end

    // Two registered read stages.
    always_ff @(posedge clk_in) begin
        rd_stage1 <= mem[addr];
        rd_stage2 <= rd_stage1;
    end

    assign rdata = rd_stage2;

endmodule

/* verilog/dmem_csr.sv */
module dmem_csr (
    input  logic                clk_in,
    input  logic                rst_in,
    input  csr_pkg::axil_req_t  axil_req,
    output csr_pkg::axil_rsp_t  axil_rsp,
    input  mem_pkg::cache_evt_t evt,
    output logic                enable,
    output logic                flush
);
    logic        wr_ready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        ar_ready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        wr_hs;
    logic        rd_hs;
    logic        wr_err;
    logic        clr_acc;
    logic        clr_miss;
    logic        clr_mis;
    logic [31:0] rd_word;
    logic        rd_err;
    logic [31:0] cnt_acc;
    logic [31:0] cnt_miss;
    logic [31:0] cnt_mis;

    assign wr_hs = wr_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_hs = ar_ready && axil_req.arvalid;

    always_comb begin
        clr_acc  = wr_hs && (axil_req.awaddr == csr_pkg::REG_ACCESSES);
        clr_miss = wr_hs && (axil_req.awaddr == csr_pkg::REG_MISSES);
        clr_mis  = wr_hs && (axil_req.awaddr == csr_pkg::REG_MISALIGNED);
        wr_err   = !(axil_req.awaddr inside {csr_pkg::REG_CTRL, csr_pkg::REG_ACCESSES,
                                             csr_pkg::REG_MISSES, csr_pkg::REG_MISALIGNED});
    end

    always_comb begin
        rd_err = 1'b0;
        case (axil_req.araddr)
            csr_pkg::REG_CTRL:       rd_word = {31'h0, enable}; // Flush reads as zero.
            csr_pkg::REG_ACCESSES:   rd_word = cnt_acc;
            csr_pkg::REG_MISSES:     rd_word = cnt_miss;
            csr_pkg::REG_MISALIGNED: rd_word = cnt_mis;
            default: begin
                rd_word = 32'h0;
                rd_err  = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= csr_pkg::RESP_OKAY;
            ar_ready <= 1'b0;
            rvalid   <= 1'b0;
            rresp    <= csr_pkg::RESP_OKAY;
            rdata    <= 32'h0;
            enable   <= 1'b1;
            flush    <= 1'b0;
        end else begin
            flush <= 1'b0;
            if (wr_hs) begin
                wr_ready <= 1'b0;
                bvalid   <= 1'b1;
                bresp    <= wr_err ? csr_pkg::RESP_SLVERR : csr_pkg::RESP_OKAY;
                if (axil_req.awaddr == csr_pkg::REG_CTRL && axil_req.wstrb[0]) begin
                    enable <= axil_req.wdata[csr_pkg::CTRL_ENABLE_BIT];
                    flush  <= axil_req.wdata[csr_pkg::CTRL_FLUSH_BIT]; // One-cycle pulse.
                end
            end else if (axil_req.awvalid && axil_req.wvalid && !wr_ready && !bvalid) begin
                wr_ready <= 1'b1;
            end
            if (bvalid && axil_req.bready) bvalid <= 1'b0;

            if (rd_hs) begin
                ar_ready <= 1'b0;
                rvalid   <= 1'b1;
                rdata    <= rd_word;
                rresp    <= rd_err ? csr_pkg::RESP_SLVERR : csr_pkg::RESP_OKAY;
            end else if (axil_req.arvalid && !ar_ready && !rvalid) begin
                ar_ready <= 1'b1;
            end
            if (rvalid && axil_req.rready) rvalid <= 1'b0;
        end
    end

    // Event counters. A clear beats a same-cycle increment.
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            cnt_acc  <= 32'h0;
            cnt_miss <= 32'h0;
            cnt_mis  <= 32'h0;
        end else begin
            if (clr_acc) cnt_acc <= 32'h0;
            else if (evt.done) cnt_acc <= cnt_acc + 32'd1;
            if (clr_miss) cnt_miss <= 32'h0;
            else if (evt.miss_start) cnt_miss <= cnt_miss + 32'd1;
            if (clr_mis) cnt_mis <= 32'h0;
            else if (evt.misaligned) cnt_mis <= cnt_mis + 32'd1;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_ready;
        axil_rsp.wready  = wr_ready;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = ar_ready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

    // A pending response keeps its payload until accepted.
    a_bresp_held: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (bvalid && !axil_req.bready) |=> (bvalid && $stable(bresp))
    );

    a_rresp_held: assert property (
        @(posedge clk_in) disable iff (rst_in)
        (rvalid && !axil_req.rready) |=> (rvalid && $stable(rdata) && $stable(rresp))
    );

endmodule

/* verilog/dmem_top.sv */
module dmem_top (
    input  logic               clk_in,
    input  logic               rst_in,
    input  mem_pkg::cpu_req_t  req,
    output logic [31:0]        rdata,
    output logic               miss,
    input  csr_pkg::axil_req_t axil_req,
    output csr_pkg::axil_rsp_t axil_rsp
);
    logic [mem_pkg::RAM_AW-1:0] mem_addr;
    logic [31:0]                mem_wdata;
    logic [3:0]                 mem_be;
    logic [31:0]                mem_rdata;
    logic                       enable;
    logic                       flush;
    mem_pkg::cache_evt_t        evt;

    riscv_dcache dcache (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req       (req),
        .rdata     (rdata),
        .miss      (miss),
        .enable    (enable),
        .flush     (flush),
        .evt       (evt),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_be    (mem_be),
        .mem_rdata (mem_rdata)
    );

    data_ram ram (
        .clk_in (clk_in),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .be     (mem_be),
        .rdata  (mem_rdata)
    );

    dmem_csr csr (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .evt      (evt),
        .enable   (enable),
        .flush    (flush)
    );

endmodule

/* sim/dmem_tb.sv */
module dmem_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT  = 40;
    localparam logic [31:0] CTRL_EN  = 32'h1 << csr_pkg::CTRL_ENABLE_BIT;
    localparam logic [31:0] CTRL_FLU = 32'h1 << csr_pkg::CTRL_FLUSH_BIT;

    logic               clk_in = 1'b0;
    logic               rst_in = 1'b1;
    mem_pkg::cpu_req_t  req = '0;
    logic [31:0]        rdata;
    logic               miss;
    csr_pkg::axil_req_t axil_req = '0;
    csr_pkg::axil_rsp_t axil_rsp;
    integer             seed = 32'hbe46;
    logic [7:0]         ref_mem [mem_pkg::RAM_WORDS*4]; // Byte image of the RAM.
    logic [31:0]        last_addr = '0;
    logic               rec_valid = 1'b0; // Model of the one-entry record.
    logic               rec_enable = 1'b1;
    int                 n_access = 0;
    int                 n_miss = 0;
    int                 n_misaligned = 0;

    dmem_top UUT (
        .clk_in   (clk_in),
        .rst_in   (rst_in),
        .req      (req),
        .rdata    (rdata),
        .miss     (miss),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    always #5 clk_in = ~clk_in;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic int size_bytes(input mem_pkg::access_size_e size);
        case (size)
            mem_pkg::SIZE_B, mem_pkg::SIZE_BU: return 1;
            mem_pkg::SIZE_H, mem_pkg::SIZE_HU: return 2;
            default:                           return 4;
        endcase
    endfunction

    function automatic logic is_misaligned(input logic [31:0] addr,
                                           input mem_pkg::access_size_e size);
        return (int'(addr[1:0]) % size_bytes(size)) != 0;
    endfunction

    function automatic void ref_store(input logic [31:0] addr, input logic [31:0] data,
                                      input mem_pkg::access_size_e size);
        logic [11:0] idx;
        if (is_misaligned(addr, size)) return;
        for (int i = 0; i < size_bytes(size); i++) begin
            idx = addr[11:0] + 12'(i);
            ref_mem[idx] = data[i*8 +: 8]; // Little endian.
        end
    endfunction

    function automatic logic [31:0] ref_load(input logic [31:0] addr,
                                             input mem_pkg::access_size_e size);
        logic [31:0] raw;
        logic [11:0] idx;
        raw = 32'h0;
        if (is_misaligned(addr, size)) return 32'h0;
        for (int i = 0; i < size_bytes(size); i++) begin
            idx = addr[11:0] + 12'(i);
            raw[i*8 +: 8] = ref_mem[idx];
        end
        case (size)
            mem_pkg::SIZE_B: return {{24{raw[7]}}, raw[7:0]};
            mem_pkg::SIZE_H: return {{16{raw[15]}}, raw[15:0]};
            default:         return raw; // Upper bytes already zero.
        endcase
    endfunction

    task automatic cpu_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input mem_pkg::access_size_e size, input logic wr,
                              output logic [31:0] data, output int miss_cycles);
        @(negedge clk_in);
        req.addr  = addr;
        req.wdata = wdata;
        req.size  = size;
        req.wr    = wr;
        req.rd    = !wr;
        miss_cycles = 0;
        #1;
        while (miss) begin
            if (miss_cycles == TIMEOUT) abort_run("Timeout: miss stayed high on a held request");
            miss_cycles++;
            @(negedge clk_in);
            #1;
        end
        data = rdata;
        n_access++;
        if (!(rec_valid && addr == last_addr)) n_miss++; // Record model predicts a miss.
        if (is_misaligned(addr, size)) n_misaligned++;
        last_addr = addr;
        rec_valid = rec_enable;
        @(negedge clk_in);
        req.wr = 1'b0;
        req.rd = 1'b0;
        repeat (2) @(negedge clk_in); // RAM read path catches up with the last write.
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] data,
                         input mem_pkg::access_size_e size, input int exp_misses);
        logic [31:0] ignored;
        int          misses;
        cpu_access(addr, data, size, 1'b1, ignored, misses);
        ref_store(addr, data, size);
        if (exp_misses >= 0) check("store miss cycles", misses, exp_misses);
    endtask

    task automatic load_check(input logic [31:0] addr, input mem_pkg::access_size_e size,
                              input int exp_misses);
        logic [31:0] data;
        int          misses;
        cpu_access(addr, 32'h0, size, 1'b0, data, misses);
        check("rdata", data, ref_load(addr, size));
        if (exp_misses >= 0) check("load miss cycles", misses, exp_misses);
    endtask

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
        int waited;
        @(negedge clk_in);
        axil_req.awaddr  = addr;
        axil_req.awvalid = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hf;
        axil_req.wvalid  = 1'b1;
        waited = 0;
        while (!axil_rsp.awready) begin
            if (waited == TIMEOUT) abort_run("Timeout: AXI write was never accepted");
            waited++;
            @(negedge clk_in);
        end
        check("wready", {31'h0, axil_rsp.wready}, 32'h1);
        @(negedge clk_in);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        waited = 0;
        while (!axil_rsp.bvalid) begin
            if (waited == TIMEOUT) abort_run("Timeout: AXI write response never arrived");
            waited++;
            @(negedge clk_in);
        end
        check("bresp", {30'h0, axil_rsp.bresp}, {30'h0, exp_resp});
        if (addr == csr_pkg::REG_CTRL) begin
            rec_enable = data[csr_pkg::CTRL_ENABLE_BIT];
            if (!rec_enable || data[csr_pkg::CTRL_FLUSH_BIT]) rec_valid = 1'b0;
        end
        @(negedge clk_in);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
        int waited;
        @(negedge clk_in);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        waited = 0;
        while (!axil_rsp.arready) begin
            if (waited == TIMEOUT) abort_run("Timeout: AXI read address was never accepted");
            waited++;
            @(negedge clk_in);
        end
        @(negedge clk_in);
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        waited = 0;
        while (!axil_rsp.rvalid) begin
            if (waited == TIMEOUT) abort_run("Timeout: AXI read data never arrived");
            waited++;
            @(negedge clk_in);
        end
        check("rdata on AXI", axil_rsp.rdata, exp_data);
        check("rresp", {30'h0, axil_rsp.rresp}, {30'h0, exp_resp});
        @(negedge clk_in);
        axil_req.rready = 1'b0;
    endtask

    task automatic test_word_round_trip();
        logic [31:0] addrs [8];
        for (int i = 0; i < 8; i++) begin
            addrs[i] = ((32'($random(seed)) & 32'h7f) << 5) | (32'(i) << 2);
            store(addrs[i], $random(seed), mem_pkg::SIZE_W, 2);
        end
        for (int i = 0; i < 8; i++) load_check(addrs[i], mem_pkg::SIZE_W, 2);
        load_check(addrs[7], mem_pkg::SIZE_W, 0);
    endtask

    task automatic test_lanes();
        logic [31:0] base;
        logic [31:0] data;
        base = 32'($random(seed)) & 32'hffc;
        for (int pass = 0; pass < 2; pass++) begin
            store(base, $random(seed), mem_pkg::SIZE_W, -1);
            for (int off = 0; off < 4; off++) begin
                data = 32'($random(seed)) | (pass == 1 ? 32'h80 : 32'h0); // Sign bit forced.
                store(base + 32'(off), data, mem_pkg::SIZE_B, -1);
            end
            for (int off = 0; off < 4; off++) begin
                load_check(base + 32'(off), mem_pkg::SIZE_B, -1);
                load_check(base + 32'(off), mem_pkg::SIZE_BU, -1);
            end
            for (int off = 0; off < 4; off += 2) begin
                data = 32'($random(seed)) | (pass == 1 ? 32'h8000 : 32'h0);
                store(base + 32'(off), data, mem_pkg::SIZE_H, -1);
                load_check(base + 32'(off), mem_pkg::SIZE_H, -1);
                load_check(base + 32'(off), mem_pkg::SIZE_HU, -1);
            end
            load_check(base, mem_pkg::SIZE_W, -1);
        end
    endtask

    task automatic test_misaligned();
        logic [31:0] base;
        base = 32'($random(seed)) & 32'hffc;
        store(base, $random(seed), mem_pkg::SIZE_W, -1);
        store(base + 32'd1, $random(seed), mem_pkg::SIZE_H, -1);
        store(base + 32'd2, $random(seed), mem_pkg::SIZE_W, -1);
        load_check(base, mem_pkg::SIZE_W, -1);
        load_check(base + 32'd1, mem_pkg::SIZE_H, -1);
        load_check(base + 32'd3, mem_pkg::SIZE_HU, -1);
        load_check(base + 32'd2, mem_pkg::SIZE_W, -1);
    endtask

    task automatic test_record_control();
        logic [31:0] addr;
        addr = (last_addr & ~32'h3) ^ 32'h40; // Differs from the recorded address.
        axil_write(csr_pkg::REG_CTRL, 32'h0, csr_pkg::RESP_OKAY);
        axil_read(csr_pkg::REG_CTRL, 32'h0, csr_pkg::RESP_OKAY);
        store(addr, $random(seed), mem_pkg::SIZE_W, 2);
        load_check(addr, mem_pkg::SIZE_W, 2);
        load_check(addr, mem_pkg::SIZE_W, 2);
        axil_write(csr_pkg::REG_CTRL, CTRL_EN, csr_pkg::RESP_OKAY);
        axil_read(csr_pkg::REG_CTRL, CTRL_EN, csr_pkg::RESP_OKAY);
        load_check(addr, mem_pkg::SIZE_W, 2);
        load_check(addr, mem_pkg::SIZE_W, 0);
        axil_write(csr_pkg::REG_CTRL, CTRL_EN | CTRL_FLU, csr_pkg::RESP_OKAY);
        load_check(addr, mem_pkg::SIZE_W, 2);
        load_check(addr, mem_pkg::SIZE_W, 0);
    endtask

    task automatic test_registers();
        axil_read(csr_pkg::REG_ACCESSES, n_access, csr_pkg::RESP_OKAY);
        axil_read(csr_pkg::REG_MISSES, n_miss, csr_pkg::RESP_OKAY);
        axil_read(csr_pkg::REG_MISALIGNED, n_misaligned, csr_pkg::RESP_OKAY);
        axil_write(csr_pkg::REG_ACCESSES, 32'hffff_ffff, csr_pkg::RESP_OKAY);
        axil_read(csr_pkg::REG_ACCESSES, 32'h0, csr_pkg::RESP_OKAY);
        axil_write(csr_pkg::REG_MISSES, 32'h1, csr_pkg::RESP_OKAY);
        axil_read(csr_pkg::REG_MISSES, 32'h0, csr_pkg::RESP_OKAY);
        axil_write(csr_pkg::REG_MISALIGNED, 32'h0, csr_pkg::RESP_OKAY);
        axil_read(csr_pkg::REG_MISALIGNED, 32'h0, csr_pkg::RESP_OKAY);
        axil_write(4'h2, 32'h0, csr_pkg::RESP_SLVERR);
        axil_read(4'h6, 32'h0, csr_pkg::RESP_SLVERR);
        axil_read(csr_pkg::REG_CTRL, CTRL_EN, csr_pkg::RESP_OKAY); // Dropped write.
    endtask

    initial begin
        repeat (8) @(posedge clk_in);
        @(negedge clk_in);
        rst_in = 1'b0;
        test_word_round_trip();
        test_lanes();
        test_misaligned();
        test_record_control();
        test_registers();
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* files.f */
common/mem_pkg.sv
common/csr_pkg.sv
dcache/riscv_dcache.sv
verilog/data_ram.sv
verilog/dmem_csr.sv
verilog/dmem_top.sv
sim/dmem_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = dmem_tb
FILELIST = files.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
